//--- hw/controlWordGen.sv
`timescale 1ns/1ps

module controlWordGen (
	input  ctrlPkg::ctrlState                  state,
	input  logic                               raIsPc,
	input  logic                               rbIsPc,
	output logic [ctrlPkg::aluSelWidth-1:0]    aluASel,
	output logic [ctrlPkg::aluSelWidth-1:0]    aluBSel,
	output logic                               memAddrSel,
	output logic                               memWdataSel,
	output logic [ctrlPkg::rdAddrWidth-1:0]    readAddrSel,
	output logic [ctrlPkg::wrAddrWidth-1:0]    writeAddrSel,
	output logic [ctrlPkg::wrDataWidth-1:0]    writeDataSel,
	output logic                               rfEn,
	output logic                               setCarry,
	output logic                               setZero,
	output logic                               addEnable,
	output logic                               memEn,
	output logic                               readWbar,
	output logic                               irWrite,
	output logic                               pcWrite
);

	import ctrlPkg::*;

	logic [aluSelWidth-1:0] aluARegSrc;
	logic [aluSelWidth-1:0] aluBRegSrc;

	// register operands naming R7 come from the PC path instead
	assign aluARegSrc = raIsPc ? aluASrcPcAsReg : aluASrcReg;
	assign aluBRegSrc = rbIsPc ? aluBSrcPcAsReg : aluBSrcReg;

	always_comb begin
		aluASel      = '0;
		aluBSel      = '0;
		memAddrSel   = 1'b0;
		memWdataSel  = 1'b0;
		readAddrSel  = '0;
		writeAddrSel = '0;
		writeDataSel = '0;
		rfEn         = 1'b0;
		setCarry     = 1'b0;
		setZero      = 1'b0;
		addEnable    = 1'b0;
		memEn        = 1'b0;
		readWbar     = 1'b0;
		irWrite      = 1'b0;
		pcWrite      = 1'b0;

		case (state)
			stFetch: begin
				memEn        = 1'b1;
				readWbar     = 1'b1;
				memAddrSel   = memAddrReg; // address from PC read port
				readAddrSel  = rdAddrPc;
				irWrite      = 1'b1;
				pcWrite      = 1'b1;
				rfEn         = 1'b1; // PC+1 back into R7
				writeAddrSel = wrAddrPc;
				writeDataSel = wrDataAlu;
				aluASel      = aluASrcFetchPc;
				aluBSel      = aluBSrcOne;
				addEnable    = 1'b1;
			end
			stDecode: begin
				readAddrSel = rdAddrRa;
			end
			stAluRR: begin
				rfEn         = 1'b1;
				setZero      = 1'b1;
				setCarry     = 1'b1;
				writeAddrSel = wrAddrRc;
				writeDataSel = wrDataAlu;
				aluASel      = aluARegSrc;
				aluBSel      = aluBRegSrc;
			end
			stAluImm: begin
				rfEn         = 1'b1;
				setZero      = 1'b1;
				setCarry     = 1'b1;
				writeAddrSel = wrAddrRb;
				writeDataSel = wrDataAlu;
				aluASel      = aluARegSrc;
				aluBSel      = aluBSrcImm6;
			end
			stLoadImm: begin
				rfEn         = 1'b1;
				writeAddrSel = wrAddrRa;
				writeDataSel = wrDataImm; // upper-immediate path
			end
			stLwAddr, stSwAddr: begin
				addEnable = 1'b1; // rb + imm6
				aluASel   = aluASrcImm6;
				aluBSel   = aluBRegSrc;
			end
			stLwMem: begin
				rfEn         = 1'b1;
				memEn        = 1'b1;
				readWbar     = 1'b1;
				memAddrSel   = memAddrAlu;
				writeAddrSel = wrAddrRa;
				writeDataSel = wrDataMem;
			end
			stSwMem: begin
				memEn       = 1'b1;
				readWbar    = 1'b0; // write cycle
				memAddrSel  = memAddrAlu;
				readAddrSel = rdAddrRa;
				memWdataSel = raIsPc;
			end
			stBeqCmp: begin
				// compare only, the datapath forms beqFlag
				aluASel = aluARegSrc;
				aluBSel = aluBRegSrc;
			end
			stBeqTake: begin
				rfEn         = 1'b1;
				addEnable    = 1'b1;
				writeAddrSel = wrAddrPc;
				writeDataSel = wrDataAlu;
				aluASel      = aluASrcPc;
				aluBSel      = aluBSrcImm6;
			end
			stJalLink: begin
				rfEn         = 1'b1;
				addEnable    = 1'b1;
				writeAddrSel = wrAddrRa; // return address
				writeDataSel = wrDataAlu;
				aluASel      = aluASrcPc;
				aluBSel      = aluBSrcOne;
			end
			stJalJump: begin
				rfEn         = 1'b1;
				addEnable    = 1'b1;
				writeAddrSel = wrAddrPc;
				writeDataSel = wrDataAlu;
				aluASel      = aluASrcPc;
				aluBSel      = aluBSrcImm9;
			end
			stJlrLink: begin
				rfEn         = 1'b1;
				addEnable    = 1'b1;
				writeAddrSel = wrAddrRa;
				writeDataSel = wrDataAlu;
				aluASel      = aluASrcPcAsReg;
				aluBSel      = aluBSrcOne;
			end
			stJlrJump: begin
				rfEn         = 1'b1;
				addEnable    = 1'b1;
				writeAddrSel = wrAddrPc;
				writeDataSel = wrDataAlu;
				aluASel      = aluASrcZero; // 0 + rb
				aluBSel      = aluBRegSrc;
			end
			default: begin
				// idle and unused codes keep the all-zero word
			end
		endcase
	end

endmodule

//--- hw/controller.sv
`timescale 1ns/1ps

module controller (
	input  logic                               clk,
	input  logic                               reset,
	input  logic [ctrlPkg::wordWidth-1:0]      ir,
	input  logic                               zeroFlag,
	input  logic                               carryFlag,
	input  logic                               beqFlag,
	output logic [ctrlPkg::aluSelWidth-1:0]    aluASel,
	output logic [ctrlPkg::aluSelWidth-1:0]    aluBSel,
	output logic                               memAddrSel,
	output logic                               memWdataSel,
	output logic [ctrlPkg::rdAddrWidth-1:0]    readAddrSel,
	output logic [ctrlPkg::wrAddrWidth-1:0]    writeAddrSel,
	output logic [ctrlPkg::wrDataWidth-1:0]    writeDataSel,
	output logic                               rfEn,
	output logic                               setCarry,
	output logic                               setZero,
	output logic                               addEnable,
	output logic                               memEn,
	output logic                               readWbar,
	output logic                               irWrite,
	output logic                               pcWrite
);

	import ctrlPkg::*;

	opcode    op;
	logic     execOk;
	logic     raIsPc;
	logic     rbIsPc;
	ctrlState state;

	instrDecoder decoder (
		.ir        (ir),
		.zeroFlag  (zeroFlag),
		.carryFlag (carryFlag),
		.op        (op),
		.execOk    (execOk),
		.raIsPc    (raIsPc),
		.rbIsPc    (rbIsPc)
	);

	stateSequencer sequencer (
		.clk     (clk),
		.reset   (reset),
		.op      (op),
		.execOk  (execOk),
		.beqFlag (beqFlag),
		.state   (state)
	);

	controlWordGen wordGen (
		.state        (state),
		.raIsPc       (raIsPc),
		.rbIsPc       (rbIsPc),
		.aluASel      (aluASel),
		.aluBSel      (aluBSel),
		.memAddrSel   (memAddrSel),
		.memWdataSel  (memWdataSel),
		.readAddrSel  (readAddrSel),
		.writeAddrSel (writeAddrSel),
		.writeDataSel (writeDataSel),
		.rfEn         (rfEn),
		.setCarry     (setCarry),
		.setZero      (setZero),
		.addEnable    (addEnable),
		.memEn        (memEn),
		.readWbar     (readWbar),
		.irWrite      (irWrite),
		.pcWrite      (pcWrite)
	);

endmodule

//--- hw/ctrlPkg.sv
package ctrlPkg;

	localparam int wordWidth = 16;

	// select widths
	localparam int aluSelWidth = 3;
	localparam int wrAddrWidth = 3;
	localparam int wrDataWidth = 2;
	localparam int rdAddrWidth = 2;

	// instruction word fields
	localparam int opMsb = 15;
	localparam int opLsb = 12;
	localparam int raMsb = 11;
	localparam int raLsb = 9;
	localparam int rbMsb = 8;
	localparam int rbLsb = 6;
	localparam int condMsb = 1;
	localparam int condLsb = 0;

	localparam logic [2:0] pcRegIndex = 3'd7; // R7 is the PC

	typedef enum logic [4:0] {
		stIdle, stFetch, stDecode, stAluRR, stAluImm, stLoadImm,
		stLwAddr, stLwMem, stSwAddr, stSwMem, stBeqCmp, stBeqTake,
		stJalLink, stJalJump, stJlrLink, stJlrJump
	} ctrlState;

	typedef enum logic [3:0] {
		opAdd = 4'b0000,
		opAdi = 4'b0001,
		opNdu = 4'b0010,
		opLhi = 4'b0011,
		opLw  = 4'b0100,
		opSw  = 4'b0101,
		opJal = 4'b1000,
		opJlr = 4'b1001,
		opBeq = 4'b1100
	} opcode;

	typedef enum logic [1:0] {
		condAlways   = 2'b00,
		condZero     = 2'b01,
		condCarry    = 2'b10,
		condReserved = 2'b11
	} condCode;

	localparam logic [aluSelWidth-1:0] aluASrcReg     = 3'b000;
	localparam logic [aluSelWidth-1:0] aluASrcImm6    = 3'b001;
	localparam logic [aluSelWidth-1:0] aluASrcFetchPc = 3'b010;
	localparam logic [aluSelWidth-1:0] aluASrcZero    = 3'b100;
	localparam logic [aluSelWidth-1:0] aluASrcPc      = 3'b110;
	localparam logic [aluSelWidth-1:0] aluASrcPcAsReg = 3'b111;

	localparam logic [aluSelWidth-1:0] aluBSrcReg     = 3'b000;
	localparam logic [aluSelWidth-1:0] aluBSrcImm9    = 3'b001;
	localparam logic [aluSelWidth-1:0] aluBSrcImm6    = 3'b010;
	localparam logic [aluSelWidth-1:0] aluBSrcOne     = 3'b011;
	localparam logic [aluSelWidth-1:0] aluBSrcPcAsReg = 3'b111;

	localparam logic [wrAddrWidth-1:0] wrAddrRa = 3'b000;
	localparam logic [wrAddrWidth-1:0] wrAddrRb = 3'b001;
	localparam logic [wrAddrWidth-1:0] wrAddrRc = 3'b010;
	localparam logic [wrAddrWidth-1:0] wrAddrPc = 3'b011;

	localparam logic [wrDataWidth-1:0] wrDataImm = 2'b00;
	localparam logic [wrDataWidth-1:0] wrDataAlu = 2'b01;
	localparam logic [wrDataWidth-1:0] wrDataMem = 2'b11;

	localparam logic [rdAddrWidth-1:0] rdAddrRa = 2'b00;
	localparam logic [rdAddrWidth-1:0] rdAddrPc = 2'b01;

	localparam logic memAddrReg = 1'b0;
	localparam logic memAddrAlu = 1'b1;

endpackage

//--- hw/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
	input  logic [ctrlPkg::wordWidth-1:0] ir,
	input  logic                          zeroFlag,
	input  logic                          carryFlag,
	output ctrlPkg::opcode                op,
	output logic                          execOk,
	output logic                          raIsPc,
	output logic                          rbIsPc
);

	import ctrlPkg::*;

	condCode cond;
	logic    condMet;

	// illegal codes pass through, sequencer sorts them out
	assign op   = opcode'(ir[opMsb:opLsb]);
	assign cond = condCode'(ir[condMsb:condLsb]);

	always_comb begin
		case (cond)
			condAlways:   condMet = 1'b1;
			condZero:     condMet = zeroFlag;
			condCarry:    condMet = carryFlag;
			condReserved: condMet = 1'b0; // never executes
			default:      condMet = 1'b0;
		endcase
	end

	// only ADD and NDU carry a condition field
	always_comb begin
		case (op)
			opAdd, opNdu: execOk = condMet;
			default:      execOk = 1'b1;
		endcase
	end

	assign raIsPc = (ir[raMsb:raLsb] == pcRegIndex);
	assign rbIsPc = (ir[rbMsb:rbLsb] == pcRegIndex);

endmodule

//--- hw/stateSequencer.sv
`timescale 1ns/1ps

module stateSequencer (
	input  logic              clk,
	input  logic              reset,
	input  ctrlPkg::opcode    op,
	input  logic              execOk,
	input  logic              beqFlag,
	output ctrlPkg::ctrlState state
);

	import ctrlPkg::*;

	ctrlState nextState;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stIdle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = stFetch; // most states end the instruction
		case (state)
			stIdle: begin
				nextState = stFetch;
			end
			stFetch: begin
				nextState = stDecode;
			end
			stDecode: begin
				case (op)
					opAdd, opNdu: begin
						// skipped conditional goes straight back
						nextState = execOk ? stAluRR : stFetch;
					end
					opAdi: begin
						nextState = stAluImm;
					end
					opLhi: begin
						nextState = stLoadImm;
					end
					opLw: begin
						nextState = stLwAddr;
					end
					opSw: begin
						nextState = stSwAddr;
					end
					opBeq: begin
						nextState = stBeqCmp;
					end
					opJal: begin
						nextState = stJalLink;
					end
					opJlr: begin
						nextState = stJlrLink;
					end
					default: begin
						nextState = stFetch; // illegal opcode
					end
				endcase
			end
			stLwAddr: begin
				nextState = stLwMem;
			end
			stSwAddr: begin
				nextState = stSwMem;
			end
			stBeqCmp: begin
				nextState = beqFlag ? stBeqTake : stFetch;
			end
			stJalLink: begin
				nextState = stJalJump;
			end
			stJlrLink: begin
				nextState = stJlrJump;
			end
			// second execute states and single execute states
			stAluRR, stAluImm, stLoadImm, stLwMem, stSwMem,
			stBeqTake, stJalJump, stJlrJump: begin
				nextState = stFetch;
			end
			default: begin
				nextState = stIdle; // unused encodings
			end
		endcase
	end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the controller testbench with Verilator and run it.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	--top-module controllerTb -f tb.f \
	-o controllerSim

./obj_dir/controllerSim | tee sim.log

if grep -q "Test failures found" sim.log; then
	echo "simulation reported failures"
	exit 1
fi

echo "simulation finished without failures"

//--- tb.f
+incdir+verif
hw/ctrlPkg.sv
hw/instrDecoder.sv
hw/stateSequencer.sv
hw/controlWordGen.sv
hw/controller.sv
verif/controllerTb.sv

//--- verif/tbVectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

task loadFixedVectors();
	// ir, zeroFlag, carryFlag, beqFlag, cycles to next irWrite,
	// then rfEn, writeAddrSel, aluASel, aluBSel of the first execute cycle
	addVector(16'h0298, 1'b0, 1'b0, 1'b0, 4'd3, 1'b1, wrAddrRc, aluASrcReg, aluBSrcReg);
	addVector(16'h0299, 1'b0, 1'b0, 1'b0, 4'd2, 1'b0, 3'b000, 3'b000, 3'b000); // adz, z clear
	addVector(16'h0299, 1'b1, 1'b0, 1'b0, 4'd3, 1'b1, wrAddrRc, aluASrcReg, aluBSrcReg);
	addVector(16'h029A, 1'b0, 1'b0, 1'b0, 4'd2, 1'b0, 3'b000, 3'b000, 3'b000); // adc, c clear
	addVector(16'h029A, 1'b0, 1'b1, 1'b0, 4'd3, 1'b1, wrAddrRc, aluASrcReg, aluBSrcReg);
	addVector(16'h0299, 1'b0, 1'b1, 1'b0, 4'd2, 1'b0, 3'b000, 3'b000, 3'b000); // wrong flag
	addVector(16'h029B, 1'b1, 1'b1, 1'b0, 4'd2, 1'b0, 3'b000, 3'b000, 3'b000); // reserved
	addVector(16'h2298, 1'b0, 1'b0, 1'b0, 4'd3, 1'b1, wrAddrRc, aluASrcReg, aluBSrcReg);
	addVector(16'h2299, 1'b0, 1'b1, 1'b0, 4'd2, 1'b0, 3'b000, 3'b000, 3'b000); // ndz skipped
	addVector(16'h229A, 1'b0, 1'b1, 1'b0, 4'd3, 1'b1, wrAddrRc, aluASrcReg, aluBSrcReg);
	// R7 in ra or rb of the ALU forms
	addVector(16'h0E98, 1'b0, 1'b0, 1'b0, 4'd3, 1'b1, wrAddrRc, aluASrcPcAsReg, aluBSrcReg);
	addVector(16'h03D8, 1'b0, 1'b0, 1'b0, 4'd3, 1'b1, wrAddrRc, aluASrcReg, aluBSrcPcAsReg);
	addVector(16'h1285, 1'b0, 1'b0, 1'b0, 4'd3, 1'b1, wrAddrRb, aluASrcReg, aluBSrcImm6);
	addVector(16'h1E85, 1'b0, 1'b0, 1'b0, 4'd3, 1'b1, wrAddrRb, aluASrcPcAsReg, aluBSrcImm6);
	addVector(16'h37AB, 1'b0, 1'b0, 1'b0, 4'd3, 1'b1, wrAddrRa, 3'b000, 3'b000); // lhi
	// loads and stores, address cycle first
	addVector(16'h4503, 1'b0, 1'b0, 1'b0, 4'd4, 1'b0, 3'b000, aluASrcImm6, aluBSrcReg);
	addVector(16'h45C3, 1'b0, 1'b0, 1'b0, 4'd4, 1'b0, 3'b000, aluASrcImm6, aluBSrcPcAsReg);
	addVector(16'h5A42, 1'b0, 1'b0, 1'b0, 4'd4, 1'b0, 3'b000, aluASrcImm6, aluBSrcReg);
	addVector(16'h5E42, 1'b0, 1'b0, 1'b0, 4'd4, 1'b0, 3'b000, aluASrcImm6, aluBSrcReg);
	// beq compare cycle, then take or fall through
	addVector(16'hC284, 1'b0, 1'b0, 1'b1, 4'd4, 1'b0, 3'b000, aluASrcReg, aluBSrcReg);
	addVector(16'hC284, 1'b0, 1'b0, 1'b0, 4'd3, 1'b0, 3'b000, aluASrcReg, aluBSrcReg);
	addVector(16'hCE84, 1'b0, 1'b0, 1'b1, 4'd4, 1'b0, 3'b000, aluASrcPcAsReg, aluBSrcReg);
	addVector(16'h8C10, 1'b0, 1'b0, 1'b0, 4'd4, 1'b1, wrAddrRa, aluASrcPc, aluBSrcOne);
	addVector(16'h8E10, 1'b0, 1'b0, 1'b0, 4'd4, 1'b1, wrAddrRa, aluASrcPc, aluBSrcOne);
	addVector(16'h9700, 1'b0, 1'b0, 1'b0, 4'd4, 1'b1, wrAddrRa, aluASrcPcAsReg, aluBSrcOne);
	addVector(16'h97C0, 1'b0, 1'b0, 1'b0, 4'd4, 1'b1, wrAddrRa, aluASrcPcAsReg, aluBSrcOne);
	// illegal opcodes fall back to fetch
	addVector(16'h6298, 1'b0, 1'b0, 1'b0, 4'd2, 1'b0, 3'b000, 3'b000, 3'b000);
	addVector(16'h7298, 1'b1, 1'b1, 1'b0, 4'd2, 1'b0, 3'b000, 3'b000, 3'b000);
	addVector(16'hA000, 1'b0, 1'b0, 1'b0, 4'd2, 1'b0, 3'b000, 3'b000, 3'b000);
	addVector(16'hF1C0, 1'b0, 1'b0, 1'b0, 4'd2, 1'b0, 3'b000, 3'b000, 3'b000);
	addVector(16'hD000, 1'b0, 1'b0, 1'b1, 4'd2, 1'b0, 3'b000, 3'b000, 3'b000); // beqFlag high
endtask

`endif

//--- verif/controllerTb.sv
`timescale 1ns/1ps

module controllerTb;

	import ctrlPkg::*;

	typedef struct packed {
		logic [15:0] ir;
		logic        zeroFlag;
		logic        carryFlag;
		logic        beqFlag;
		logic [3:0]  cycles; // fetch to next fetch
		logic        rfEn;
		logic [2:0]  wrAddr;
		logic [2:0]  aluA;
		logic [2:0]  aluB;
	} vecRow;

	logic                   clk;
	logic                   reset;
	logic [wordWidth-1:0]   ir;
	logic                   zeroFlag;
	logic                   carryFlag;
	logic                   beqFlag;
	logic [aluSelWidth-1:0] aluASel;
	logic [aluSelWidth-1:0] aluBSel;
	logic                   memAddrSel;
	logic                   memWdataSel;
	logic [rdAddrWidth-1:0] readAddrSel;
	logic [wrAddrWidth-1:0] writeAddrSel;
	logic [wrDataWidth-1:0] writeDataSel;
	logic                   rfEn;
	logic                   setCarry;
	logic                   setZero;
	logic                   addEnable;
	logic                   memEn;
	logic                   readWbar;
	logic                   irWrite;
	logic                   pcWrite;
	logic [6:0]             strobes;

	vecRow rows[$];
	int    seed;
	int    errors;
	int    checks;
	int    cycleCount;
	int    timeoutLimit;
	int    rowIdx;

	assign strobes = {rfEn, setCarry, setZero, addEnable, memEn, irWrite, pcWrite};

	controller UUT (
		.clk(clk), .reset(reset), .ir(ir),
		.zeroFlag(zeroFlag), .carryFlag(carryFlag), .beqFlag(beqFlag),
		.aluASel(aluASel), .aluBSel(aluBSel),
		.memAddrSel(memAddrSel), .memWdataSel(memWdataSel),
		.readAddrSel(readAddrSel), .writeAddrSel(writeAddrSel), .writeDataSel(writeDataSel),
		.rfEn(rfEn), .setCarry(setCarry), .setZero(setZero), .addEnable(addEnable),
		.memEn(memEn), .readWbar(readWbar), .irWrite(irWrite), .pcWrite(pcWrite)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
			$display("Timeout: irWrite sequence stalled, run stopped after %0d cycles", cycleCount);
			$display("Test failures found");
			$finish;
		end
	end

	task checkValue(input string name, input logic [31:0] actual, input logic [31:0] expected);
		checks = checks + 1;
		if (actual !== expected) begin
			errors = errors + 1;
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h (vector %0d, %0t)",
				name, actual, expected, rowIdx, $time);
		end
	endtask

	task addVector(input logic [15:0] irWord, input logic z, input logic c, input logic b,
			input logic [3:0] cyc, input logic en, input logic [2:0] wa,
			input logic [2:0] aa, input logic [2:0] ab);
		vecRow row;
		row = {irWord, z, c, b, cyc, en, wa, aa, ab};
		rows.push_back(row);
	endtask

	`include "tbVectors.svh"

	// random register fields, expectations follow the R7 substitution rule
	task addRandomVectors(input int count);
		logic [31:0] r;
		logic [2:0]  ra;
		logic [2:0]  rb;
		logic [2:0]  rc;
		logic [5:0]  imm;
		logic [2:0]  expA;
		logic [2:0]  expB;
		for (int i = 0; i < count; i++) begin
			r = $random(seed);
			ra = r[2:0];
			rb = r[5:3];
			rc = r[8:6];
			imm = r[14:9];
			expA = (ra == 3'd7) ? aluASrcPcAsReg : aluASrcReg;
			expB = (rb == 3'd7) ? aluBSrcPcAsReg : aluBSrcReg;
			case (i % 3)
				0: addVector({4'b0000, ra, rb, rc, 3'b000}, 1'b0, 1'b0, 1'b0, 4'd3, 1'b1,
					wrAddrRc, expA, expB);
				1: addVector({4'b0001, ra, rb, imm}, 1'b0, 1'b0, 1'b0, 4'd3, 1'b1,
					wrAddrRb, expA, aluBSrcImm6);
				default: addVector({4'b0100, ra, rb, imm}, 1'b0, 1'b0, 1'b0, 4'd4, 1'b0,
					3'b000, aluASrcImm6, expB);
			endcase
		end
	endtask

	task checkExecute(input vecRow row);
		checkValue("rfEn", 32'(rfEn), 32'(row.rfEn));
		checkValue("writeAddrSel", 32'(writeAddrSel), 32'(row.wrAddr));
		checkValue("aluASel", 32'(aluASel), 32'(row.aluA));
		checkValue("aluBSel", 32'(aluBSel), 32'(row.aluB));
		if (row.ir[15:12] inside {4'b0000, 4'b0001, 4'b0010}) begin
			checkValue("setZero", 32'(setZero), 32'd1); // ALU ops update both flags
			checkValue("setCarry", 32'(setCarry), 32'd1);
		end
	endtask

	task checkSecondExecute(input vecRow row);
		case (row.ir[15:12])
			4'b0100: begin
				checkValue("memEn", 32'(memEn), 32'd1);
				checkValue("readWbar", 32'(readWbar), 32'd1);
				checkValue("memAddrSel", 32'(memAddrSel), 32'(memAddrAlu));
				checkValue("writeDataSel", 32'(writeDataSel), 32'(wrDataMem));
			end
			4'b0101: begin
				checkValue("memEn", 32'(memEn), 32'd1);
				checkValue("readWbar", 32'(readWbar), 32'd0);
				checkValue("memAddrSel", 32'(memAddrSel), 32'(memAddrAlu));
				checkValue("memWdataSel", 32'(memWdataSel), 32'(row.ir[11:9] == 3'd7));
			end
			default: begin // beq taken, jal and jlr jump into the PC
				checkValue("rfEn", 32'(rfEn), 32'd1);
				checkValue("writeAddrSel", 32'(writeAddrSel), 32'(wrAddrPc));
			end
		endcase
	endtask

	// called on the falling edge of a fetch cycle
	task runVector(input vecRow row);
		int cyc;
		ir = row.ir;
		zeroFlag = row.zeroFlag;
		carryFlag = row.carryFlag;
		beqFlag = row.beqFlag;
		cyc = 0;
		do begin
			@(negedge clk);
			cyc = cyc + 1;
			if (cyc == 1) checkValue("decode strobes", 32'(strobes), 32'd0);
			if (cyc == 2 && row.cycles > 4'd2) checkExecute(row);
			if (cyc == 3 && row.cycles == 4'd4) checkSecondExecute(row);
		end while (irWrite !== 1'b1);
		checkValue("cycles to irWrite", 32'(cyc), 32'(row.cycles));
	endtask

	initial begin
		int total;
		seed = 30713;
		errors = 0;
		checks = 0;
		rowIdx = -1;
		timeoutLimit = 0;
		reset = 1'b1;
		ir = '0;
		zeroFlag = 1'b0;
		carryFlag = 1'b0;
		beqFlag = 1'b0;
		loadFixedVectors();
		addRandomVectors(12);
		total = 0;
		foreach (rows[i]) total = total + int'(rows[i].cycles);
		timeoutLimit = 8 * total + 20;

		repeat (4) begin
			@(negedge clk);
			checkValue("reset strobes", 32'(strobes), 32'd0);
		end
		reset = 1'b0;
		checkValue("idle selects", 32'({aluASel, aluBSel, memAddrSel, memWdataSel,
			readAddrSel, writeAddrSel, writeDataSel, readWbar}), 32'd0); // idle until the next edge
		@(negedge clk);
		checkValue("irWrite", 32'(irWrite), 32'd1);
		checkValue("memEn", 32'(memEn), 32'd1);
		checkValue("readWbar", 32'(readWbar), 32'd1);
		checkValue("pcWrite", 32'(pcWrite), 32'd1);
		checkValue("addEnable", 32'(addEnable), 32'd1);
		checkValue("readAddrSel", 32'(readAddrSel), 32'(rdAddrPc));

		foreach (rows[i]) begin
			rowIdx = i;
			runVector(rows[i]);
		end

		$display("Summary: %0d vectors, %0d checks, %0d errors", rows.size(), checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
